/* hw/axi_fetch_top.sv */
`timescale 1ns/1ns

// instruction fetch bridge: requester port to AXI4 read master
module axi_fetch_top
    import fetch_pkg::*;
(
    input  logic            clock,
    input  logic            reset,        // async, active low

    // fetch requester
    input  logic            rw_valid_i,   // held until rw_ready_o
    input  logic [XLEN-1:0] rw_addr_i,    // held with rw_valid_i
    output logic            rw_ready_o,   // one-cycle reply pulse
    output logic [XLEN-1:0] data_read_o,  // valid with rw_ready_o
    output logic            rw_err_o,     // bus error on this fetch

    // AXI read address channel
    input  logic            ar_ready_i,
    output logic            ar_valid_o,
    output logic [XLEN-1:0] ar_addr_o,

    // AXI read data channel
    input  logic            r_valid_i,
    output logic            r_ready_o,
    input  logic [XLEN-1:0] r_data_i,
    input  logic [1:0]      r_resp_i,
    input  logic            r_last_i
);

    logic hit;    // buffer to FSM
    logic fill;   // FSM to buffer and timer
    logic reply;  // FSM to buffer
    logic stale;  // timer to buffer

    // held request address goes straight onto AR
    assign ar_addr_o = rw_addr_i;

    fetch_ctrl_fsm u_fsm (
        .clock      (clock),
        .reset      (reset),
        .rw_valid_i (rw_valid_i),
        .hit_i      (hit),
        .ar_ready_i (ar_ready_i),
        .r_valid_i  (r_valid_i),
        .ar_valid_o (ar_valid_o),
        .r_ready_o  (r_ready_o),
        .fill_o     (fill),
        .reply_o    (reply)
    );

    buf_age_timer u_timer (
        .clock   (clock),
        .reset   (reset),
        .fill_i  (fill),
        .stale_o (stale)
    );

    fetch_line_buf u_buf (
        .clock       (clock),
        .reset       (reset),
        .rw_addr_i   (rw_addr_i),
        .r_data_i    (r_data_i),
        .r_resp_i    (r_resp_i),
        .r_last_i    (r_last_i),
        .fill_i      (fill),
        .reply_i     (reply),
        .stale_i     (stale),
        .hit_o       (hit),
        .data_read_o (data_read_o),
        .rw_err_o    (rw_err_o),
        .rw_ready_o  (rw_ready_o)
    );

endmodule

/* hw/buf_age_timer.sv */
`timescale 1ns/1ns

// counts cycles since the last fill, saturates at the lifetime
module buf_age_timer
    import fetch_pkg::*;
(
    input  logic clock,
    input  logic reset,   // async, active low
    input  logic fill_i,  // buffer written this cycle
    output logic stale_o  // entry too old to answer a hit
);

    logic [AGE_W-1:0] age_q;
    logic             at_limit;

    assign at_limit = (age_q >= AGE_W'(BUF_LIFETIME));

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            age_q <= AGE_W'(BUF_LIFETIME); // start out stale
        end else if (fill_i) begin
            age_q <= '0;                    // fresh word
        end else if (!at_limit) begin
            age_q <= age_q + 1'b1;
        end
    end

    assign stale_o = at_limit;

    // saturation must hold across every fill and idle stretch
    a_age_bounded : assert property (
        @(posedge clock) disable iff (!reset)
        age_q <= AGE_W'(BUF_LIFETIME)
    ) else $error("age counter ran past BUF_LIFETIME");

endmodule

/* hw/fetch_ctrl_fsm.sv */
`timescale 1ns/1ns

// sequences one fetch through lookup, the AR and R handshakes and the reply
module fetch_ctrl_fsm
    import fetch_pkg::*;
(
    input  logic clock,
    input  logic reset,       // async, active low

    // requester side
    input  logic rw_valid_i,  // held until the reply pulse
    input  logic hit_i,       // buffer holds a fresh copy of rw_addr_i

    // AXI read handshakes
    input  logic ar_ready_i,
    input  logic r_valid_i,
    output logic ar_valid_o,
    output logic r_ready_o,

    // strobes to the buffer and the age timer
    output logic fill_o,      // R handshake cycle
    output logic reply_o      // high for the one DONE cycle
);

    logic [1:0] state_q;
    logic [1:0] state_d;

    // state register
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // next state
    always_comb begin
        state_d = state_q; // hold by default
        case (state_q)
            ST_IDLE: begin
                // request only looked at here
                if (rw_valid_i) begin
                    if (hit_i) begin
                        state_d = ST_DONE; // answered from the buffer
                    end else begin
                        state_d = ST_AR;   // go to the bus
                    end
                end
            end
            ST_AR: begin
                if (ar_ready_i) begin
                    state_d = ST_R; // address accepted
                end
            end
            ST_R: begin
                // single beat, so valid ends the burst
                if (r_valid_i) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: begin
                state_d = ST_IDLE; // exactly one cycle
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // outputs decoded from the state and never from the request
    assign ar_valid_o = (state_q == ST_AR);
    assign r_ready_o  = (state_q == ST_R);
    assign fill_o     = (state_q == ST_R) && r_valid_i; // beat accepted
    assign reply_o    = (state_q == ST_DONE);

    // once raised the AXI address stays offered until taken
    a_ar_valid_held : assert property (
        @(posedge clock) disable iff (!reset)
        ar_valid_o && !ar_ready_i |=> ar_valid_o
    ) else $error("ar_valid_o dropped before ar_ready_i");

    // data phase opens only right after the address was taken
    a_r_after_ar : assert property (
        @(posedge clock) disable iff (!reset)
        $rose(r_ready_o) |-> $past(ar_valid_o && ar_ready_i)
    ) else $error("r_ready_o raised without an AR handshake");

endmodule

/* hw/fetch_line_buf.sv */
`timescale 1ns/1ns

// one-entry fetch buffer: last good word, its address, reply data
module fetch_line_buf
    import fetch_pkg::*;
(
    input  logic            clock,
    input  logic            reset,       // async, active low

    // request address, stable while a fetch runs
    input  logic [XLEN-1:0] rw_addr_i,

    // AXI R beat
    input  logic [XLEN-1:0] r_data_i,
    input  logic [1:0]      r_resp_i,
    input  logic            r_last_i,

    // control from the FSM and the timer
    input  logic            fill_i,      // R handshake
    input  logic            reply_i,     // DONE state
    input  logic            stale_i,     // entry past its lifetime

    output logic            hit_o,
    output logic [XLEN-1:0] data_read_o,
    output logic            rw_err_o,
    output logic            rw_ready_o
);

    logic [XLEN-1:0] addr_q;   // address of the last fill
    logic [XLEN-1:0] data_q;   // word of the last fill
    logic            valid_q;  // last fill came back okay
    logic            err_q;    // last fill came back with an error
    logic            resp_ok;
    logic            resp_err;

    assign resp_ok  = (r_resp_i == RESP_OKAY);
    assign resp_err = |(r_resp_i & RESP_SLVERR); // slverr or decerr

    // payload, written on every beat
    always_ff @(posedge clock) begin
        if (fill_i) begin
            addr_q <= rw_addr_i; // requester still holds it here
            data_q <= r_data_i;
        end
    end

    // entry flags
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid_q <= 1'b0;
            err_q   <= 1'b0;
        end else if (fill_i) begin
            valid_q <= resp_ok;  // errors leave the entry empty
            err_q   <= resp_err;
        end
    end

    // fresh matching entry answers without the bus
    assign hit_o = valid_q && (addr_q == rw_addr_i) && !stale_i;

    // reply strobe follows the DONE state
    // on a hit err_q is clear since only okay fills set valid
    assign rw_ready_o  = reply_i;
    assign data_read_o = data_q;
    assign rw_err_o    = err_q;

    // single-beat reads only, so each accepted beat closes its burst
    a_fill_is_last : assert property (
        @(posedge clock) disable iff (!reset)
        fill_i |-> r_last_i
    ) else $error("read beat without r_last_i");

endmodule

/* hw/fetch_pkg.sv */
// shared constants for the instruction fetch bridge
package fetch_pkg;

    // address and data width, one fetch word per beat
    localparam int XLEN = 64;

    // cycles after a fill before the buffered word must be refetched
    localparam int BUF_LIFETIME = 16;

    // age counter must hold BUF_LIFETIME itself when saturated
    localparam int AGE_W = $clog2(BUF_LIFETIME) + 1;

    // AXI read response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10; // bit 1 also set for decerr

    // fetch FSM states
    // one bit changes per step along the miss path
    localparam logic [1:0] ST_IDLE = 2'b00; // waiting for a request
    localparam logic [1:0] ST_AR   = 2'b01; // address phase on AR
    localparam logic [1:0] ST_R    = 2'b11; // waiting for the read beat
    localparam logic [1:0] ST_DONE = 2'b10; // one-cycle reply to requester

endpackage

/* run_sim.sh */
#!/bin/sh
# build the fetch bridge testbench with Verilator and run it
# a $fatal in the run gives a nonzero exit status
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_axi_fetch -f vlog.f -o tb_axi_fetch &&
./obj_dir/tb_axi_fetch ||
{ echo "fetch bridge build or run did not pass"; exit 1; }

/* sim/axi_rd_mem_model.sv */
`timescale 1ns/1ns

// AXI read slave, single beats, delays set per request by the testbench
module axi_rd_mem_model
    import fetch_pkg::*;
#(
    parameter logic [XLEN-1:0] PATTERN = '0, // word = address ^ PATTERN
    parameter int              ERR_BIT = 12  // this address bit set gives slverr
) (
    input  logic            clock,
    input  logic            reset,       // async, active low

    // extra wait cycles before ar_ready and before r_valid
    input  logic [2:0]      ar_dly_i,
    input  logic [2:0]      r_dly_i,

    // read address channel
    input  logic            ar_valid_i,
    input  logic [XLEN-1:0] ar_addr_i,
    output logic            ar_ready_o,

    // read data channel
    input  logic            r_ready_i,
    output logic            r_valid_o,
    output logic [XLEN-1:0] r_data_o,
    output logic [1:0]      r_resp_o,
    output logic            r_last_o
);

    logic            data_phase_q; // address taken, beat still owed
    logic [2:0]      wait_q;       // cycles waited in the current phase
    logic [XLEN-1:0] addr_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ar_ready_o   <= 1'b0;
            r_valid_o    <= 1'b0;
            r_data_o     <= '0;
            r_resp_o     <= RESP_OKAY;
            r_last_o     <= 1'b0;
            data_phase_q <= 1'b0;
            wait_q       <= '0;
            addr_q       <= '0;
        end else if (!data_phase_q) begin
            if (ar_valid_i && ar_ready_o) begin
                // AR handshake on this edge
                ar_ready_o   <= 1'b0;
                addr_q       <= ar_addr_i;
                wait_q       <= '0;
                data_phase_q <= 1'b1;
            end else if (ar_valid_i) begin
                if (wait_q >= ar_dly_i) begin
                    ar_ready_o <= 1'b1;
                end else begin
                    wait_q <= wait_q + 3'd1; // stall the address
                end
            end
        end else begin
            if (r_valid_o && r_ready_i) begin
                r_valid_o    <= 1'b0; // beat taken
                r_last_o     <= 1'b0;
                data_phase_q <= 1'b0;
                wait_q       <= '0;
            end else if (!r_valid_o) begin
                if (wait_q >= r_dly_i) begin
                    r_valid_o <= 1'b1;
                    r_data_o  <= addr_q ^ PATTERN; // whole address feeds the word
                    r_resp_o  <= addr_q[ERR_BIT] ? RESP_SLVERR : RESP_OKAY;
                    r_last_o  <= 1'b1;              // single beat
                end else begin
                    wait_q <= wait_q + 3'd1;
                end
            end
        end
    end

endmodule

/* sim/tb_axi_fetch.sv */
`timescale 1ns/1ns

// random fetch traffic checked against a model of the one-entry buffer
module tb_axi_fetch
    import fetch_pkg::*;
();

    localparam logic [XLEN-1:0] PATTERN = 64'h5a3c_96f0_0ff0_c3a5;
    localparam int          ERR_BIT       = 12;  // error region of the memory
    localparam int          NUM_ROUNDS    = 250;
    localparam int          REPLY_TIMEOUT = 40;  // cycles from request to reply
    localparam int          RESET_TIMEOUT = 20;
    localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;

    logic            clock;
    logic            reset;
    logic            rw_valid;
    logic [XLEN-1:0] rw_addr;
    logic            rw_ready;
    logic [XLEN-1:0] data_read;
    logic            rw_err;
    logic            ar_ready;
    logic            ar_valid;
    logic [XLEN-1:0] ar_addr;
    logic            r_valid;
    logic            r_ready;
    logic [XLEN-1:0] r_data;
    logic [1:0]      r_resp;
    logic            r_last;
    logic [2:0]      ar_dly;
    logic [2:0]      r_dly;

    logic [31:0]     lfsr_q;
    int              cyc = 0;        // cycle index read at falling edges
    logic            good_valid;     // model of the buffer valid flag
    logic [XLEN-1:0] good_addr;
    int              good_fill_cyc;  // cycle of its R handshake in the model
    logic [XLEN-1:0] last_addr;      // last address requested
    logic            last_err;
    int              hit_count;
    int              stale_count;
    int              err_repeat_count;

    tb_clock_gen u_clk (
        .clock_o (clock),
        .reset_o (reset)
    );

    axi_fetch_top i_dut (
        .clock       (clock),
        .reset       (reset),
        .rw_valid_i  (rw_valid),
        .rw_addr_i   (rw_addr),
        .rw_ready_o  (rw_ready),
        .data_read_o (data_read),
        .rw_err_o    (rw_err),
        .ar_ready_i  (ar_ready),
        .ar_valid_o  (ar_valid),
        .ar_addr_o   (ar_addr),
        .r_valid_i   (r_valid),
        .r_ready_o   (r_ready),
        .r_data_i    (r_data),
        .r_resp_i    (r_resp),
        .r_last_i    (r_last)
    );

    axi_rd_mem_model #(
        .PATTERN (PATTERN),
        .ERR_BIT (ERR_BIT)
    ) u_mem (
        .clock      (clock),
        .reset      (reset),
        .ar_dly_i   (ar_dly),
        .r_dly_i    (r_dly),
        .ar_valid_i (ar_valid),
        .ar_addr_i  (ar_addr),
        .ar_ready_o (ar_ready),
        .r_ready_i  (r_ready),
        .r_valid_o  (r_valid),
        .r_data_o   (r_data),
        .r_resp_o   (r_resp),
        .r_last_o   (r_last)
    );

    always @(posedge clock) cyc <= cyc + 1;

    // galois step that shifts the random bit out of bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q); // one step per bit
        end
        return v;
    endfunction

    // aligned address outside the error region
    function automatic logic [XLEN-1:0] new_addr();
        logic [XLEN-1:0] hi;
        logic [XLEN-1:0] lo;
        hi = XLEN'(rand_bits(16)) << 32;
        lo = XLEN'(rand_bits(9)) << 3; // bits 3..11 only
        return hi | lo;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic report_error(input string msg);
        fail_run($sformatf("[ERROR] t=%0t %s", $time, msg));
    endtask

    task automatic check_quiet();
        assert (!rw_ready && !ar_valid && !r_ready)
        else report_error("rw_ready_o, ar_valid_o or r_ready_o high with no request");
    endtask

    // requester idle for n cycles and ending on a rising edge
    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clock);
            check_quiet();
            @(posedge clock);
        end
    endtask

    // one request issued gap idle cycles after the previous reply
    task automatic run_fetch(input logic [XLEN-1:0] addr, input int gap);
        logic       exp_hit;
        logic       exp_err;
        logic       got_reply;
        logic       ar_waiting;
        logic [2:0] ar_wait;
        logic [2:0] r_wait;
        int         sample_cyc;
        int         fill_cyc;
        int         reply_cyc;
        int         ar_count;
        exp_hit    = 1'b0;
        exp_err    = 1'b0;
        got_reply  = 1'b0;
        ar_waiting = 1'b0;
        sample_cyc = 0;
        fill_cyc   = -1;
        reply_cyc  = 0;
        ar_count   = 0;
        ar_wait    = 3'(rand_bits(3) % 6); // 0..5 slave stall cycles
        r_wait     = 3'(rand_bits(3) % 6);
        @(posedge clock);
        if (gap > 0) begin
            rw_valid <= 1'b0;
            idle_cycles(gap);
        end
        rw_valid <= 1'b1;
        rw_addr  <= addr;
        ar_dly   <= ar_wait;
        r_dly    <= r_wait;
        for (int n = 0; n < REPLY_TIMEOUT && !got_reply; n++) begin
            @(negedge clock);
            if (n == 0) begin
                // FSM idle and sampling the request this cycle
                sample_cyc = cyc;
                exp_hit = good_valid && (addr == good_addr)
                          && (sample_cyc - good_fill_cyc - 1) < BUF_LIFETIME;
                exp_err = !exp_hit && addr[ERR_BIT];
                assert (!rw_ready && !ar_valid)
                else report_error("reply or AR in the cycle the request is sampled");
            end
            if (n == 1) begin
                assert (ar_valid == !exp_hit)
                else report_error($sformatf("ar_valid_o=%0b after request, expected %0b",
                                            ar_valid, !exp_hit));
            end
            if (ar_waiting) begin
                assert (ar_valid) else report_error("ar_valid_o dropped before ar_ready_i");
            end
            if (ar_valid) begin
                assert (!exp_hit) else report_error("AR issued for a buffer hit");
                assert (ar_addr == addr)
                else report_error($sformatf("ar_addr_o %h, expected %h", ar_addr, addr));
                if (ar_ready) ar_count++;
            end
            ar_waiting = ar_valid && !ar_ready;
            if (r_valid && r_ready) fill_cyc = cyc; // R handshake
            if (rw_ready) begin
                got_reply = 1'b1;
                reply_cyc = cyc;
            end
        end
        if (!got_reply) begin
            fail_run($sformatf("timeout: no rw_ready_o within %0d cycles for address %h",
                               REPLY_TIMEOUT, addr));
        end
        if (exp_hit) begin
            assert (reply_cyc == sample_cyc + 1 && ar_count == 0 && fill_cyc < 0)
            else report_error("buffer hit not answered in the next cycle without the bus");
        end else begin
            assert (ar_count == 1)
            else report_error($sformatf("%0d AR handshakes for one miss", ar_count));
            assert (fill_cyc >= 0 && reply_cyc == fill_cyc + 1)
            else report_error("rw_ready_o not in the cycle after the R handshake");
        end
        assert (rw_err == exp_err)
        else report_error($sformatf("rw_err_o=%0b for %h, expected %0b", rw_err, addr, exp_err));
        if (!exp_err) begin
            assert (data_read == (addr ^ PATTERN))
            else report_error($sformatf("data_read_o %h for %h, expected %h",
                                        data_read, addr, addr ^ PATTERN));
        end
        if (exp_hit) begin
            hit_count++;
        end else if (good_valid && addr == good_addr) begin
            stale_count++; // aged out and fetched again
        end
        if (exp_err && last_err && addr == last_addr) err_repeat_count++;
        if (!exp_hit) begin
            good_valid    = !exp_err; // errors never buffered
            good_addr     = addr;
            good_fill_cyc = fill_cyc;
        end
        last_addr = addr;
        last_err  = exp_err;
    endtask

    initial begin
        logic [XLEN-1:0] addr;
        int              kind;
        int              gap;
        int              waited;
        rw_valid         = 1'b0;
        rw_addr          = '0;
        ar_dly           = '0;
        r_dly            = '0;
        lfsr_q           = 32'hc077;
        good_valid       = 1'b0;
        good_addr        = '0;
        good_fill_cyc    = -1000;
        last_addr        = '0;
        last_err         = 1'b0;
        hit_count        = 0;
        stale_count      = 0;
        err_repeat_count = 0;
        waited           = 0;
        // outputs quiet through reset and a few cycles after
        // first look is at a falling edge well inside reset
        do begin
            @(negedge clock);
            check_quiet();
            waited++;
        end while (waited < RESET_TIMEOUT && reset !== 1'b1);
        if (reset !== 1'b1) begin
            fail_run("timeout: reset was never released");
        end
        idle_cycles(3);
        for (int i = 0; i < NUM_ROUNDS; i++) begin
            kind = int'(rand_bits(2));
            gap  = int'(rand_bits(2)); // 0..3 idle cycles
            case (kind)
                0: run_fetch(new_addr(), gap);
                1: run_fetch(last_addr, gap); // quick repeat
                2: run_fetch(last_addr, 2 * BUF_LIFETIME + int'(rand_bits(3)));
                default: begin
                    addr = new_addr() | (XLEN'(1) << ERR_BIT);
                    run_fetch(addr, gap);
                    run_fetch(addr, 0); // must go to the bus again
                end
            endcase
        end
        @(posedge clock);
        rw_valid <= 1'b0;
        idle_cycles(4);
        if (hit_count == 0 || stale_count == 0 || err_repeat_count == 0) begin
            fail_run("random run never produced a hit, a stale refetch and an error repeat");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ns

// testbench clock and active-low reset
module tb_clock_gen (
    output logic clock_o,
    output logic reset_o
);

    localparam int HALF_PERIOD  = 2; // 4 ns clock
    localparam int RESET_CYCLES = 4; // rising edges that see reset low

    initial begin
        clock_o = 1'b0;
        forever #HALF_PERIOD clock_o = ~clock_o;
    end

    initial begin
        reset_o = 1'b1;
        #1 reset_o = 1'b0; // real falling edge, async resets fire before the first edge
        repeat (RESET_CYCLES) @(posedge clock_o);
        reset_o <= 1'b1;
    end

endmodule

/* vlog.f */
hw/fetch_pkg.sv
hw/fetch_ctrl_fsm.sv
hw/buf_age_timer.sv
hw/fetch_line_buf.sv
hw/axi_fetch_top.sv
sim/tb_clock_gen.sv
sim/axi_rd_mem_model.sv
sim/tb_axi_fetch.sv
